// File: hw/pwmAudioPkg.sv
`default_nettype none

`include "s32xPwm_cfg.svh"

package pwmAudioPkg;

	typedef logic [`PWM_PW_WIDTH-1:0] pulseWidth_t;
	typedef logic [`PWM_PW_WIDTH-1:0] cycle_t;      // Clocks per sample period
	typedef logic [`PWM_TM_WIDTH-1:0] timeCount_t;  // Sample periods per interrupt

	// Re-centred output sample
	typedef logic signed [`PWM_DATA_WIDTH-1:0] sample_t;

endpackage

`default_nettype wire

// File: hw/pwmFifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "s32xPwm_cfg.svh"

module pwmFifo (
	input  wire                           CLK,
	input  wire                           RST_N,
	input  wire                           push,
	input  wire                           pop,
	input  wire pwmAudioPkg::pulseWidth_t pushData,
	output pwmAudioPkg::pulseWidth_t      head,
	output pwmAudioPkg::sample_t          sample,
	output logic                          full,
	output logic                          empty
);
	import pwmAudioPkg::*;

	pulseWidth_t mem [`PWM_FIFO_DEPTH];
	logic [1:0]  rdPtr;
	logic [1:0]  wrPtr;
	logic [1:0]  count;
	pulseWidth_t lastPw;   // Last popped entry
	pulseWidth_t pwDiff;
	logic        doPush;
	logic        doPop;

	// Wrap at the queue depth
	function automatic logic [1:0] nextPtr(input logic [1:0] ptr);
		nextPtr = (ptr == `PWM_FIFO_DEPTH - 1) ? 2'd0 : ptr + 2'd1;
	endfunction

	assign full   = (count == `PWM_FIFO_DEPTH);
	assign empty  = (count == 2'd0);
	assign doPush = push & ~full;
	assign doPop  = pop & ~empty;

	always_ff @(posedge CLK) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdPtr  <= '0;
			wrPtr  <= '0;
			count  <= '0;
			lastPw <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop) begin
				rdPtr  <= nextPtr(rdPtr);
				lastPw <= mem[rdPtr];
			end

			case ({doPush, doPop})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: ;  // Push and pop cancel
			endcase
		end
	end

	assign head = empty ? lastPw : mem[rdPtr];

	// Mid-scale becomes zero, then scale up to 16 bits
	assign pwDiff = head - `PWM_PW_OFFSET;
	assign sample = {pwDiff, 4'h0};

endmodule

`default_nettype wire

// File: hw/pwmRegPkg.sv
`default_nettype none

`include "s32xPwm_cfg.svh"

package pwmRegPkg;

	// APB register offset
	typedef logic [`PWM_ADDR_WIDTH-1:0] apbAddr_t;

	// APB data word
	typedef logic [`PWM_DATA_WIDTH-1:0] regData_t;

	// Control register with fields at the PWM_CTRL_* positions
	typedef logic [`PWM_DATA_WIDTH-1:0] ctrlReg_t;

endpackage

`default_nettype wire

// File: hw/pwmRegs.sv
`timescale 1ns/10ps
`default_nettype none

`include "s32xPwm_cfg.svh"

module pwmRegs (
	input  wire                        CLK,
	input  wire                        RST_N,

	input  wire                        pSel,
	input  wire                        pEnable,
	input  wire                        pWrite,
	input  wire pwmRegPkg::apbAddr_t   pAddr,
	input  wire pwmRegPkg::regData_t   pWdata,
	output pwmRegPkg::regData_t        pRdata,
	output logic                       pReady,

	input  wire pwmAudioPkg::pulseWidth_t headLeft,
	input  wire pwmAudioPkg::pulseWidth_t headRight,
	input  wire                        fullLeft,
	input  wire                        emptyLeft,
	input  wire                        fullRight,
	input  wire                        emptyRight,

	output pwmRegPkg::ctrlReg_t        ctrl,
	output pwmAudioPkg::cycle_t        cycle,
	output logic                       pushLeft,
	output logic                       pushRight,
	output pwmAudioPkg::pulseWidth_t   pushData,
	output logic                       intClear
);
	import pwmAudioPkg::*;

	logic        access;
	logic        wrEn;
	logic        rdEn;
	pulseWidth_t wrPw;

	assign access = pSel & pEnable;
	assign wrEn   = access & pWrite;
	assign rdEn   = access & ~pWrite;
	assign wrPw   = pWdata[`PWM_PW_WIDTH-1:0];

	assign pReady = 1'b1; // Zero wait states

	// Clear acts at the same edge as the write
	assign intClear = wrEn && (pAddr == `PWM_ADDR_ICLR);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ctrl      <= '0;
			cycle     <= '0;
			pushData  <= '0;
			pushLeft  <= 1'b0;
			pushRight <= 1'b0;
		end else begin
			pushLeft  <= 1'b0;
			pushRight <= 1'b0;

			if (wrEn) begin
				case (pAddr)
					`PWM_ADDR_CTRL: begin
						ctrl <= pWdata & `PWM_CTRL_MASK;
					end
					`PWM_ADDR_CYCLE: begin
						cycle <= wrPw;
					end
					`PWM_ADDR_LEFT: begin
						pushData <= wrPw;
						pushLeft <= ctrl[`PWM_CTRL_LEN];
					end
					`PWM_ADDR_RIGHT: begin
						pushData  <= wrPw;
						pushRight <= ctrl[`PWM_CTRL_REN];
					end
					`PWM_ADDR_MONO: begin
						// Same value into both queues
						pushData  <= wrPw;
						pushLeft  <= ctrl[`PWM_CTRL_LEN];
						pushRight <= ctrl[`PWM_CTRL_REN];
					end
					default: ;
				endcase
			end
		end
	end

	// Channel words carry status in the top two bits
	always_comb begin
		pRdata = '0;
		if (rdEn) begin
			case (pAddr)
				`PWM_ADDR_CTRL:  pRdata = ctrl;
				`PWM_ADDR_CYCLE: pRdata = {{(`PWM_DATA_WIDTH-`PWM_PW_WIDTH){1'b0}}, cycle};
				`PWM_ADDR_LEFT:  pRdata = {fullLeft, emptyLeft, 2'b00, headLeft};
				`PWM_ADDR_RIGHT: pRdata = {fullRight, emptyRight, 2'b00, headRight};
				default:         pRdata = '0;  // Mono and clear are write only
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/pwmTimer.sv
`timescale 1ns/10ps
`default_nettype none

`include "s32xPwm_cfg.svh"

module pwmTimer (
	input  wire                       CLK,
	input  wire                       RST_N,
	input  wire pwmRegPkg::ctrlReg_t  ctrl,
	input  wire pwmAudioPkg::cycle_t  cycle,
	input  wire                       intClear,
	output logic                      periodEnd,
	output logic                      pwmIrq,
	output logic                      pwmDreq
);
	import pwmAudioPkg::*;

	logic       run;
	cycle_t     cycCnt;
	cycle_t     reload;
	timeCount_t tmCnt;
	timeCount_t tmNext;
	timeCount_t tmField;
	logic       lastPeriod;
	logic       dreqFlag;

	assign run = ctrl[`PWM_CTRL_LEN] | ctrl[`PWM_CTRL_REN];

	// Cycle of 0 wraps to a 4096 clock period
	assign reload = cycle - 1'b1;

	assign tmField    = ctrl[`PWM_CTRL_TM_LSB +: `PWM_TM_WIDTH];
	assign tmNext     = tmCnt - 1'b1;
	assign lastPeriod = (tmNext == '0);  // TM of 0 gives 16 periods

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycCnt    <= '0;
			periodEnd <= 1'b0;
		end else if (!run) begin
			cycCnt    <= reload;
			periodEnd <= 1'b0;
		end else if (cycCnt == '0) begin
			cycCnt    <= reload;
			periodEnd <= 1'b1;
		end else begin
			cycCnt    <= cycCnt - 1'b1;
			periodEnd <= 1'b0;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tmCnt    <= '0;
			pwmIrq   <= 1'b0;
			dreqFlag <= 1'b0;
		end else begin
			if (intClear)
				pwmIrq <= 1'b0;

			if (!run) begin
				tmCnt <= tmField;
			end else if (periodEnd) begin
				dreqFlag <= 1'b0;
				if (lastPeriod) begin
					tmCnt    <= tmField;
					dreqFlag <= ctrl[`PWM_CTRL_RTP];
					if (ctrl[`PWM_CTRL_IEN])
						pwmIrq <= 1'b1;  // Set wins over a clear
				end else begin
					tmCnt <= tmNext;
				end
			end
		end
	end

	// Request drops at once when RTP is turned off
	assign pwmDreq = dreqFlag & ctrl[`PWM_CTRL_RTP];

endmodule

`default_nettype wire

// File: hw/s32xPwm.sv
`timescale 1ns/10ps
`default_nettype none

module s32xPwm (
	input  wire                      CLK,
	input  wire                      RST_N,

	input  wire                      pSel,
	input  wire                      pEnable,
	input  wire                      pWrite,
	input  wire pwmRegPkg::apbAddr_t pAddr,
	input  wire pwmRegPkg::regData_t pWdata,
	output pwmRegPkg::regData_t      pRdata,
	output logic                     pReady,

	output pwmAudioPkg::sample_t     pwmLeft,
	output pwmAudioPkg::sample_t     pwmRight,
	output logic                     pwmIrq,
	output logic                     pwmDreq
);
	import pwmRegPkg::*;
	import pwmAudioPkg::*;

	ctrlReg_t    ctrl;
	cycle_t      cycle;
	pulseWidth_t pushData;
	pulseWidth_t headLeft;
	pulseWidth_t headRight;
	logic        pushLeft;
	logic        pushRight;
	logic        fullLeft;
	logic        emptyLeft;
	logic        fullRight;
	logic        emptyRight;
	logic        intClear;
	logic        periodEnd;  // Pops both queues

	pwmRegs regs (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.pSel       (pSel),
		.pEnable    (pEnable),
		.pWrite     (pWrite),
		.pAddr      (pAddr),
		.pWdata     (pWdata),
		.pRdata     (pRdata),
		.pReady     (pReady),
		.headLeft   (headLeft),
		.headRight  (headRight),
		.fullLeft   (fullLeft),
		.emptyLeft  (emptyLeft),
		.fullRight  (fullRight),
		.emptyRight (emptyRight),
		.ctrl       (ctrl),
		.cycle      (cycle),
		.pushLeft   (pushLeft),
		.pushRight  (pushRight),
		.pushData   (pushData),
		.intClear   (intClear)
	);

	pwmFifo leftFifo (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.push     (pushLeft),
		.pop      (periodEnd),
		.pushData (pushData),
		.head     (headLeft),
		.sample   (pwmLeft),
		.full     (fullLeft),
		.empty    (emptyLeft)
	);

	pwmFifo rightFifo (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.push     (pushRight),
		.pop      (periodEnd),
		.pushData (pushData),
		.head     (headRight),
		.sample   (pwmRight),
		.full     (fullRight),
		.empty    (emptyRight)
	);

	pwmTimer timer (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ctrl      (ctrl),
		.cycle     (cycle),
		.intClear  (intClear),
		.periodEnd (periodEnd),
		.pwmIrq    (pwmIrq),
		.pwmDreq   (pwmDreq)
	);

endmodule

`default_nettype wire

// File: include/s32xPwm_cfg.svh
`ifndef S32XPWM_CFG_SVH
`define S32XPWM_CFG_SVH

`define PWM_DATA_WIDTH   16
`define PWM_ADDR_WIDTH   4
`define PWM_PW_WIDTH     12
`define PWM_TM_WIDTH     4
`define PWM_FIFO_DEPTH   3
`define PWM_PW_OFFSET    12'h800

`define PWM_ADDR_CTRL    4'h0
`define PWM_ADDR_CYCLE   4'h2
`define PWM_ADDR_LEFT    4'h4
`define PWM_ADDR_RIGHT   4'h6
`define PWM_ADDR_MONO    4'h8
`define PWM_ADDR_ICLR    4'hA

`define PWM_CTRL_LEN     0
`define PWM_CTRL_REN     1
`define PWM_CTRL_IEN     6
`define PWM_CTRL_RTP     7
`define PWM_CTRL_TM_LSB  8
`define PWM_CTRL_MASK    16'h0FC3

`endif

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	-f s32xPwm.f \
	--top-module s32xPwm_tb \
	-o s32xPwm_sim \
	&& ./obj_dir/s32xPwm_sim \
	|| exit 1

// File: s32xPwm.f
+incdir+include
hw/pwmRegPkg.sv
hw/pwmAudioPkg.sv
hw/pwmRegs.sv
hw/pwmFifo.sv
hw/pwmTimer.sv
hw/s32xPwm.sv
test/s32xPwm_chk.sv
test/s32xPwm_tb.sv

// File: test/s32xPwm_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "s32xPwm_cfg.svh"

module s32xPwm_chk (
	input wire                      CLK,
	input wire                      RST_N,
	input wire                      pSel,
	input wire                      pEnable,
	input wire                      pReady,
	input wire pwmRegPkg::ctrlReg_t ctrl,
	input wire                      pwmIrq,
	input wire                      pwmDreq,
	input wire                      fullLeft,
	input wire                      emptyLeft,
	input wire                      fullRight,
	input wire                      emptyRight
);

	// No wait states on the APB side
	readyInAccess: assert property (@(posedge CLK) disable iff (!RST_N)
		pSel && pEnable |-> pReady)
		else $error("pReady low during an APB access phase");

	leftFlags: assert property (@(posedge CLK) disable iff (!RST_N)
		!(fullLeft && emptyLeft))
		else $error("Left queue full and empty at once");

	rightFlags: assert property (@(posedge CLK) disable iff (!RST_N)
		!(fullRight && emptyRight))
		else $error("Right queue full and empty at once");

	// Set uses the control value before the edge
	irqNeedsIen: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(pwmIrq) |-> $past(ctrl[`PWM_CTRL_IEN]))
		else $error("pwmIrq rose with interrupts disabled");

	dreqNeedsRtp: assert property (@(posedge CLK) disable iff (!RST_N)
		!ctrl[`PWM_CTRL_RTP] |-> !pwmDreq)
		else $error("pwmDreq high with DMA requests disabled");

endmodule

`default_nettype wire

// File: test/s32xPwm_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "s32xPwm_cfg.svh"

module s32xPwm_tb;
	import pwmRegPkg::*;
	import pwmAudioPkg::*;

	localparam int ApbLimit  = 8;
	localparam int PopLimit  = 5000;  // Longer than a 4096 clock period
	localparam int IrqLimit  = 100;
	localparam int DreqCycle = 4;
	localparam int DreqTm    = 3;

	logic        CLK;
	logic        RST_N;
	logic        pSel;
	logic        pEnable;
	logic        pWrite;
	apbAddr_t    pAddr;
	regData_t    pWdata;
	regData_t    pRdata;
	logic        pReady;
	sample_t     pwmLeft;
	sample_t     pwmRight;
	logic        pwmIrq;
	logic        pwmDreq;

	logic [31:0] seed = 32'hf69;
	ctrlReg_t    ctrlModel = '0;
	pulseWidth_t qLeft[$];
	pulseWidth_t qRight[$];
	pulseWidth_t lastLeft = '0;
	pulseWidth_t lastRight = '0;
	regData_t    rdWord;

	s32xPwm s32xPwm_inst (
		.CLK(CLK), .RST_N(RST_N), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWdata(pWdata), .pRdata(pRdata), .pReady(pReady),
		.pwmLeft(pwmLeft), .pwmRight(pwmRight), .pwmIrq(pwmIrq), .pwmDreq(pwmDreq)
	);

	bind s32xPwm s32xPwm_chk chk (
		.CLK(CLK), .RST_N(RST_N), .pSel(pSel), .pEnable(pEnable), .pReady(pReady),
		.ctrl(ctrl), .pwmIrq(pwmIrq), .pwmDreq(pwmDreq), .fullLeft(fullLeft),
		.emptyLeft(emptyLeft), .fullRight(fullRight), .emptyRight(emptyRight)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic pulseWidth_t nextPw();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[23:12];
	endfunction

	// Expected sample with mid-scale at zero and 16 steps per count
	function automatic sample_t refSample(input pulseWidth_t pw);
		int centred;
		centred = int'(pw) - 'h800;
		return sample_t'(centred * 16);
	endfunction

	function automatic ctrlReg_t ctrlWord(input bit len, input bit ren, input bit ien,
			input bit rtp, input timeCount_t tm);
		ctrlReg_t c;
		c = '0;
		c[`PWM_CTRL_LEN] = len;
		c[`PWM_CTRL_REN] = ren;
		c[`PWM_CTRL_IEN] = ien;
		c[`PWM_CTRL_RTP] = rtp;
		c[`PWM_CTRL_TM_LSB +: `PWM_TM_WIDTH] = tm;
		return c;
	endfunction

	function automatic pulseWidth_t expHead(input bit left);
		if (left)
			return (qLeft.size() > 0) ? qLeft[0] : lastLeft;
		return (qRight.size() > 0) ? qRight[0] : lastRight;
	endfunction

	function automatic regData_t statusWord(input int size, input pulseWidth_t head);
		regData_t w;
		w = '0;
		w[15] = (size == `PWM_FIFO_DEPTH);
		w[14] = (size == 0);
		w[`PWM_PW_WIDTH-1:0] = head;
		return w;
	endfunction

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkSample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp)
			failRun($sformatf("ERROR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkReg(input string name, input regData_t exp, input regData_t act);
		if (act !== exp)
			failRun($sformatf("ERROR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkFlag(input string name, input bit exp, input logic act);
		if (act !== exp)
			failRun($sformatf("ERROR %s expected %b actual %b", name, exp, act));
	endtask

	task automatic apbAccess(input logic wr, input apbAddr_t addr, input regData_t data);
		int n;
		n = 0;
		@(posedge CLK);
		pSel    <= 1'b1;
		pEnable <= 1'b0;
		pWrite  <= wr;
		pAddr   <= addr;
		pWdata  <= data;
		@(posedge CLK);
		pEnable <= 1'b1;
		do begin
			@(negedge CLK);
			n++;
		end while (pReady !== 1'b1 && n < ApbLimit);
		if (pReady !== 1'b1)
			failRun("APB slave never raised pReady");
		rdWord = pRdata;
		@(posedge CLK);  // Access phase ends here
		pSel    <= 1'b0;
		pEnable <= 1'b0;
	endtask

	task automatic apbRead(input apbAddr_t addr);
		apbAccess(1'b0, addr, '0);
	endtask

	// Write plus the queue model's view of it
	task automatic apbWrite(input apbAddr_t addr, input regData_t data);
		pulseWidth_t v;
		bit toLeft;
		bit toRight;
		v = data[`PWM_PW_WIDTH-1:0];
		toLeft = (addr == `PWM_ADDR_LEFT) || (addr == `PWM_ADDR_MONO);
		toRight = (addr == `PWM_ADDR_RIGHT) || (addr == `PWM_ADDR_MONO);
		apbAccess(1'b1, addr, data);
		if (toLeft && ctrlModel[`PWM_CTRL_LEN] && qLeft.size() < `PWM_FIFO_DEPTH)
			qLeft.push_back(v);
		if (toRight && ctrlModel[`PWM_CTRL_REN] && qRight.size() < `PWM_FIFO_DEPTH)
			qRight.push_back(v);
		if (addr == `PWM_ADDR_CTRL)
			ctrlModel = data & `PWM_CTRL_MASK;
	endtask

	task automatic waitPop();
		int n;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (s32xPwm_inst.periodEnd !== 1'b1 && n < PopLimit);
		if (s32xPwm_inst.periodEnd !== 1'b1)
			failRun("No sample period ended before the timeout");
		@(negedge CLK);  // Pop lands on the edge in between
		if (qLeft.size() > 0)
			lastLeft = qLeft.pop_front();
		if (qRight.size() > 0)
			lastRight = qRight.pop_front();
	endtask

	task automatic waitIrq();
		int n;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (pwmIrq !== 1'b1 && n < IrqLimit);
		if (pwmIrq !== 1'b1)
			failRun("pwmIrq did not rise before the timeout");
	endtask

	task automatic waitDreq();
		int n;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (pwmDreq !== 1'b1 && n < IrqLimit);
		if (pwmDreq !== 1'b1)
			failRun("pwmDreq did not rise before the timeout");
	endtask

	task automatic checkStatus(input string name);
		apbRead(`PWM_ADDR_LEFT);
		checkReg({name, "Left"}, statusWord(qLeft.size(), expHead(1'b1)), rdWord);
		apbRead(`PWM_ADDR_RIGHT);
		checkReg({name, "Right"}, statusWord(qRight.size(), expHead(1'b0)), rdWord);
	endtask

	task automatic checkOutputs(input string name);
		@(negedge CLK);
		checkSample({name, "Left"}, refSample(expHead(1'b1)), pwmLeft);
		checkSample({name, "Right"}, refSample(expHead(1'b0)), pwmRight);
	endtask

	initial begin
		RST_N   = 1'b0;
		pSel    = 1'b0;
		pEnable = 1'b0;
		pWrite  = 1'b0;
		pAddr   = '0;
		pWdata  = '0;
		repeat (10) @(posedge CLK);
		RST_N <= 1'b1;

		// Reset values and register readback
		checkOutputs("reset");
		checkFlag("resetIrq", 1'b0, pwmIrq);
		checkFlag("resetDreq", 1'b0, pwmDreq);
		apbRead(`PWM_ADDR_CTRL);
		checkReg("resetCtrl", '0, rdWord);
		apbRead(`PWM_ADDR_CYCLE);
		checkReg("resetCycle", '0, rdWord);
		apbWrite(`PWM_ADDR_CTRL, 16'hFFFF);
		apbRead(`PWM_ADDR_CTRL);
		checkReg("ctrlMask", ctrlWord(1'b1, 1'b1, 1'b1, 1'b1, 4'hF), rdWord);
		apbWrite(`PWM_ADDR_CYCLE, 16'hFFFF);
		apbRead(`PWM_ADDR_CYCLE);
		checkReg("cycleMask", regData_t'((1 << `PWM_PW_WIDTH) - 1), rdWord);
		apbRead(`PWM_ADDR_MONO);
		checkReg("monoRead", '0, rdWord);
		apbWrite(`PWM_ADDR_CTRL, '0);
		apbWrite(`PWM_ADDR_CYCLE, '0);

		// Cycle 0 and TM 0, so no pop while filling
		apbWrite(`PWM_ADDR_CTRL, ctrlWord(1'b1, 1'b0, 1'b0, 1'b0, 4'd0));
		repeat (3) apbWrite(`PWM_ADDR_LEFT, regData_t'(nextPw()));
		checkStatus("full");
		apbWrite(`PWM_ADDR_LEFT, regData_t'(nextPw()));
		checkStatus("overflow");
		checkOutputs("overflow");

		// Write order through both outputs, then the hold when empty
		apbWrite(`PWM_ADDR_CTRL, ctrlWord(1'b1, 1'b1, 1'b0, 1'b0, 4'd0));
		repeat (3) apbWrite(`PWM_ADDR_RIGHT, regData_t'(nextPw()));
		checkOutputs("firstHead");
		for (int i = 0; i < 4; i++) begin
			waitPop();
			checkOutputs($sformatf("pop%0d", i));
		end
		checkStatus("drained");

		// Mono and a disabled channel
		apbWrite(`PWM_ADDR_CTRL, ctrlWord(1'b0, 1'b1, 1'b0, 1'b0, 4'd0));
		apbWrite(`PWM_ADDR_LEFT, regData_t'(nextPw()));
		apbWrite(`PWM_ADDR_MONO, regData_t'(nextPw()));
		checkStatus("leftOff");
		apbWrite(`PWM_ADDR_CTRL, ctrlWord(1'b1, 1'b1, 1'b0, 1'b0, 4'd0));
		apbWrite(`PWM_ADDR_MONO, regData_t'(nextPw()));
		checkStatus("mono");
		checkOutputs("mono");

		// Interrupt set, hold and clear
		apbWrite(`PWM_ADDR_CTRL, '0);
		apbWrite(`PWM_ADDR_CYCLE, regData_t'(DreqCycle));
		apbWrite(`PWM_ADDR_CTRL, ctrlWord(1'b1, 1'b0, 1'b1, 1'b0, 4'd2));
		waitIrq();
		apbWrite(`PWM_ADDR_CTRL, ctrlWord(1'b1, 1'b0, 1'b0, 1'b0, 4'd2));
		@(negedge CLK);
		checkFlag("irqHold", 1'b1, pwmIrq);
		apbWrite(`PWM_ADDR_ICLR, '0);
		@(negedge CLK);
		checkFlag("irqClear", 1'b0, pwmIrq);
		for (int i = 0; i < IrqLimit; i++) begin
			@(negedge CLK);
			checkFlag("irqMasked", 1'b0, pwmIrq);
		end

		// One request period high out of every TM periods
		apbWrite(`PWM_ADDR_CTRL, ctrlWord(1'b1, 1'b0, 1'b0, 1'b1, 4'(DreqTm)));
		waitDreq();
		for (int i = 1; i < 2 * DreqTm * DreqCycle; i++) begin
			@(negedge CLK);
			checkFlag("dreqPulse", (i % (DreqTm * DreqCycle)) < DreqCycle, pwmDreq);
		end
		apbWrite(`PWM_ADDR_CTRL, ctrlWord(1'b1, 1'b0, 1'b0, 1'b0, 4'(DreqTm)));
		for (int i = 0; i < 2 * DreqTm * DreqCycle; i++) begin
			@(negedge CLK);
			checkFlag("dreqOff", 1'b0, pwmDreq);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
